// File: src/mc_config.svh
/*
 * Size limits of the matrix engine.
 * MC_MEM_DEPTH must equal MC_MAX_SIDE squared.
 * MC_ADDR_W must be log2 of MC_MEM_DEPTH.
 */
`ifndef MC_CONFIG_SVH
`define MC_CONFIG_SVH

// element width, values kept below 2^31-1
`define MC_DATA_W 31

`define MC_MAX_SIDE 16

`define MC_MEM_DEPTH 256
`define MC_ADDR_W 8

`endif

// File: src/mc_op_pkg.sv
/*
 * Command encodings used by the controller and the address mapper.
 * MULT is listed only so that the opcode values stay fixed.
 * Codes 6 and 7 are reserved and have no name.
 */
package mc_op_pkg;

	typedef enum logic [2:0] {
		SETUP     = 3'd0,
		ADDITION  = 3'd1,
		MULT      = 3'd2,
		TRANSPOSE = 3'd3,
		MIRROR    = 3'd4,
		ROTATE    = 3'd5
	} action_t;

	// side = 2 << code
	typedef logic [1:0] size_code_t;

endpackage

// File: src/mc_mem_pkg.sv
/*
 * Storage types of the matrix engine.
 * Elements are stored row-major, so row r and column c sit at r*side+c.
 */
`include "mc_config.svh"

package mc_mem_pkg;

	// one matrix element
	typedef logic [`MC_DATA_W-1:0] elem_t;

	// element address in either memory
	typedef logic [`MC_ADDR_W-1:0] addr_t;

endpackage

// File: src/matrix_ram.sv
/*
 * Behavioral single-port element memory with a registered read.
 * Read data comes one cycle after the address and returns the old word on a write.
 * The contents have no reset.
 */
`timescale 1ns/10ps
`include "mc_config.svh"

module matrix_ram (
	input  logic              clk,
	input  mc_mem_pkg::addr_t addr,
	input  mc_mem_pkg::elem_t wdata,
	input  logic              we,
	output mc_mem_pkg::elem_t rdata
);

	mc_mem_pkg::elem_t mem [0:`MC_MEM_DEPTH-1];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// File: src/perm_addr.sv
/*
 * Destination address of one element for transpose, mirror and rotate.
 * Purely combinational. The side must be a power of two.
 */
`timescale 1ns/10ps
`include "mc_config.svh"

module perm_addr (
	input  mc_op_pkg::action_t    action,
	input  mc_op_pkg::size_code_t size,
	input  mc_mem_pkg::addr_t     perm_idx,
	output mc_mem_pkg::addr_t     perm_dst
);

	localparam int IDX_W = $clog2(`MC_MAX_SIDE);

	// log2 of the side
	logic [2:0]       shift;
	logic [IDX_W-1:0] side_m1;
	logic [IDX_W-1:0] row;
	logic [IDX_W-1:0] col;
	logic [IDX_W-1:0] col_rev;

	always_comb begin
		shift   = {1'b0, size} + 3'd1;
		side_m1 = IDX_W'((1 << shift) - 1);
		row     = IDX_W'(perm_idx >> shift);
		col     = IDX_W'(perm_idx) & side_m1;
		// side-1-c
		col_rev = side_m1 - col;

		case (action)
			mc_op_pkg::TRANSPOSE: begin
				perm_dst = (mc_mem_pkg::addr_t'(col) << shift) | mc_mem_pkg::addr_t'(row);
			end
			mc_op_pkg::MIRROR: begin
				perm_dst = (mc_mem_pkg::addr_t'(row) << shift) | mc_mem_pkg::addr_t'(col_rev);
			end
			// quarter turn counter-clockwise
			mc_op_pkg::ROTATE: begin
				perm_dst = (mc_mem_pkg::addr_t'(col_rev) << shift) | mc_mem_pkg::addr_t'(row);
			end
			default: begin
				perm_dst = perm_idx;
			end
		endcase
	end

endmodule

// File: src/mc_ctrl.sv
/*
 * Command controller of the matrix engine, without back-pressure.
 * A new command may start only after the last out_valid beat of the previous one.
 * MULT and the reserved opcodes are ignored while idle.
 */
`timescale 1ns/10ps
`include "mc_config.svh"

module mc_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  mc_mem_pkg::elem_t     in_data,
	input  mc_op_pkg::size_code_t size,
	input  mc_op_pkg::action_t    action,
	output logic                  out_valid,
	output mc_mem_pkg::elem_t     out_data,
	output mc_mem_pkg::addr_t     mat_addr,
	output mc_mem_pkg::elem_t     mat_wdata,
	output logic                  mat_we,
	input  mc_mem_pkg::elem_t     mat_rdata,
	output mc_mem_pkg::addr_t     scratch_addr,
	output mc_mem_pkg::elem_t     scratch_wdata,
	output logic                  scratch_we,
	input  mc_mem_pkg::elem_t     scratch_rdata,
	output mc_mem_pkg::addr_t     perm_idx,
	output mc_op_pkg::action_t    perm_action,
	output mc_op_pkg::size_code_t perm_size,
	input  mc_mem_pkg::addr_t     perm_dst
);

	localparam int CNT_W = `MC_ADDR_W + 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_INPUT,
		S_PERMUTE,
		S_WRITE_BACK,
		S_OUTPUT_STREAM,
		S_OUTPUT_ZERO
	} state_t;

	state_t                state;
	state_t                state_nxt;
	mc_op_pkg::action_t    act_q;
	mc_op_pkg::size_code_t size_q;
	logic [CNT_W-1:0]      cnt;
	logic [CNT_W-1:0]      n_elem;
	logic [3:0]            n_shift;
	logic                  last;
	mc_mem_pkg::addr_t     idx_cur;
	mc_mem_pkg::addr_t     idx_prev;
	mc_mem_pkg::elem_t     in_data_q;
	mc_mem_pkg::elem_t     add_data_q;
	logic [`MC_DATA_W:0]   raw_sum;
	mc_mem_pkg::elem_t     fold_sum;
	mc_mem_pkg::elem_t     add_sum;
	logic                  stream_valid;
	mc_mem_pkg::elem_t     stream_data;

	// side^2 elements
	assign n_shift  = {1'b0, size_q, 1'b0} + 4'd2;
	assign n_elem   = CNT_W'(1) << n_shift;
	// every phase runs side^2+1 cycles, cnt 0..side^2
	assign last     = (cnt == n_elem);
	assign idx_cur  = mc_mem_pkg::addr_t'(cnt);
	assign idx_prev = mc_mem_pkg::addr_t'(cnt - 1'b1);

	assign perm_idx    = idx_prev;
	assign perm_action = act_q;
	assign perm_size   = size_q;

	// modulo 2^31-1 by end-around carry
	assign raw_sum  = {1'b0, mat_rdata} + {1'b0, add_data_q};
	assign fold_sum = raw_sum[`MC_DATA_W-1:0] + mc_mem_pkg::elem_t'(raw_sum[`MC_DATA_W]);
	assign add_sum  = (&fold_sum) ? '0 : fold_sum;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			cnt    <= '0;
			act_q  <= mc_op_pkg::SETUP;
			size_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == S_IDLE || last)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			if (state == S_IDLE && in_valid) begin
				act_q <= action;
				if (action == mc_op_pkg::SETUP)
					size_q <= size;
			end
		end
	end

	// input beat and its copy aligned with the mat_ram read
	always_ff @(posedge clk) begin
		in_data_q  <= in_data;
		add_data_q <= in_data_q;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (in_valid) begin
					case (action)
						mc_op_pkg::SETUP, mc_op_pkg::ADDITION:
							state_nxt = S_INPUT;
						mc_op_pkg::TRANSPOSE, mc_op_pkg::MIRROR, mc_op_pkg::ROTATE:
							state_nxt = S_PERMUTE;
						default:
							state_nxt = S_IDLE;
					endcase
				end
			end
			S_INPUT:         if (last) state_nxt = S_OUTPUT_STREAM;
			S_PERMUTE:       if (last) state_nxt = S_WRITE_BACK;
			S_WRITE_BACK:    if (last) state_nxt = S_OUTPUT_ZERO;
			S_OUTPUT_STREAM: if (last) state_nxt = S_IDLE;
			S_OUTPUT_ZERO:   state_nxt = S_IDLE;
			default:         state_nxt = S_IDLE;
		endcase
	end

	// memory ports, reads at cnt and writes one element behind
	always_comb begin
		mat_addr      = idx_cur;
		mat_wdata     = in_data_q;
		mat_we        = 1'b0;
		scratch_addr  = idx_cur;
		scratch_wdata = add_sum;
		scratch_we    = 1'b0;
		case (state)
			S_INPUT: begin
				if (act_q == mc_op_pkg::SETUP) begin
					mat_we = !last;
				end else begin
					scratch_addr = idx_prev;
					scratch_we   = (cnt != '0);
				end
			end
			S_PERMUTE: begin
				scratch_addr  = perm_dst;
				scratch_wdata = mat_rdata;
				scratch_we    = (cnt != '0);
			end
			S_WRITE_BACK: begin
				mat_addr  = idx_prev;
				mat_wdata = scratch_rdata;
				mat_we    = (cnt != '0);
			end
			S_OUTPUT_STREAM: begin
				// addition result goes back to mat_ram as it streams out
				if (act_q == mc_op_pkg::ADDITION) begin
					mat_addr  = idx_prev;
					mat_wdata = scratch_rdata;
					mat_we    = (cnt != '0);
				end
			end
			default: begin
				mat_we = 1'b0;
			end
		endcase
	end

	assign stream_valid = (state == S_OUTPUT_STREAM) && (cnt != '0);
	assign stream_data  = (act_q == mc_op_pkg::SETUP) ? mat_rdata : scratch_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else if (stream_valid) begin
			out_valid <= 1'b1;
			out_data  <= stream_data;
		end else begin
			// single zero beat closes a rearrangement
			out_valid <= (state == S_OUTPUT_ZERO);
			out_data  <= '0;
		end
	end

endmodule

// File: src/mc_top.sv
/*
 * Matrix engine top level with one stored matrix of up to 16x16 elements.
 * Timing is that of the controller. There is no back-pressure on the output.
 */
`timescale 1ns/10ps

module mc_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  mc_mem_pkg::elem_t     in_data,
	input  mc_op_pkg::size_code_t size,
	input  mc_op_pkg::action_t    action,
	output logic                  out_valid,
	output mc_mem_pkg::elem_t     out_data
);

	mc_mem_pkg::addr_t     mat_addr;
	mc_mem_pkg::elem_t     mat_wdata;
	logic                  mat_we;
	mc_mem_pkg::elem_t     mat_rdata;
	mc_mem_pkg::addr_t     scratch_addr;
	mc_mem_pkg::elem_t     scratch_wdata;
	logic                  scratch_we;
	mc_mem_pkg::elem_t     scratch_rdata;
	mc_mem_pkg::addr_t     perm_idx;
	mc_op_pkg::action_t    perm_action;
	mc_op_pkg::size_code_t perm_size;
	mc_mem_pkg::addr_t     perm_dst;

	mc_ctrl mc_ctrl_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.size          (size),
		.action        (action),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.mat_addr      (mat_addr),
		.mat_wdata     (mat_wdata),
		.mat_we        (mat_we),
		.mat_rdata     (mat_rdata),
		.scratch_addr  (scratch_addr),
		.scratch_wdata (scratch_wdata),
		.scratch_we    (scratch_we),
		.scratch_rdata (scratch_rdata),
		.perm_idx      (perm_idx),
		.perm_action   (perm_action),
		.perm_size     (perm_size),
		.perm_dst      (perm_dst)
	);

	perm_addr perm_addr_i (
		.action   (perm_action),
		.size     (perm_size),
		.perm_idx (perm_idx),
		.perm_dst (perm_dst)
	);

	// current matrix
	matrix_ram mat_ram (
		.clk   (clk),
		.addr  (mat_addr),
		.wdata (mat_wdata),
		.we    (mat_we),
		.rdata (mat_rdata)
	);

	// sums and rearranged copies
	matrix_ram scratch_ram (
		.clk   (clk),
		.addr  (scratch_addr),
		.wdata (scratch_wdata),
		.we    (scratch_we),
		.rdata (scratch_rdata)
	);

endmodule

// File: sim/mc_ref.svh
/*
 * Reference model helpers for the matrix engine testbench.
 * Included inside the testbench module. Elements are kept below 2^31-1.
 */
`ifndef MC_REF_SVH
`define MC_REF_SVH

// (a + b) mod 2^31-1
function automatic mc_mem_pkg::elem_t mod_add(mc_mem_pkg::elem_t a, mc_mem_pkg::elem_t b);
	longint modulus;
	longint sum;
	modulus = (longint'(1) << `MC_DATA_W) - 1;
	sum     = longint'(a) + longint'(b);
	return mc_mem_pkg::elem_t'(sum % modulus);
endfunction

// where element idx lands after a rearrangement, row-major r*side+c
function automatic int rearr_dst(mc_op_pkg::action_t act, int side, int idx);
	int r;
	int c;
	int dst;
	r = idx / side;
	c = idx % side;
	case (act)
		mc_op_pkg::TRANSPOSE: dst = c * side + r;
		mc_op_pkg::MIRROR:    dst = r * side + (side - 1 - c);
		// counter-clockwise quarter turn
		mc_op_pkg::ROTATE:    dst = (side - 1 - c) * side + r;
		default:              dst = idx;
	endcase
	return dst;
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

`endif

// File: sim/tb_mc.sv
/*
 * Testbench for mc_top. Inputs change on the falling edge, outputs are sampled there too.
 * Stops at the first mismatch. A watchdog limits the run to a budget per command.
 */
`timescale 1ns/10ps
`include "mc_config.svh"

module tb_mc;

	`include "mc_ref.svh"

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	mc_mem_pkg::elem_t     in_data;
	mc_op_pkg::size_code_t size;
	mc_op_pkg::action_t    action;
	logic                  out_valid;
	mc_mem_pkg::elem_t     out_data;

	logic [31:0]           lfsr;
	mc_mem_pkg::elem_t     model [0:`MC_MEM_DEPTH-1];
	mc_mem_pkg::elem_t     stim  [0:`MC_MEM_DEPTH-1];
	mc_mem_pkg::elem_t     saved [0:`MC_MEM_DEPTH-1];
	mc_mem_pkg::elem_t     exp_q [$];
	mc_mem_pkg::elem_t     elem_max;
	mc_mem_pkg::elem_t     near_max;
	mc_op_pkg::size_code_t cur_code;
	int                    cur_side;
	int                    got_beats;
	int                    exp_beats;
	int                    cycles;
	int                    budget;
	int                    sel;
	string                 cur_test;

	mc_top mc_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.size      (size),
		.action    (action),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_elem(string name, mc_mem_pkg::elem_t exp, mc_mem_pkg::elem_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			$display("[FAIL] %s beat count expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	// one bit per lfsr step
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic mc_mem_pkg::elem_t rand_elem();
		mc_mem_pkg::elem_t v;
		v = mc_mem_pkg::elem_t'(rand_bits(`MC_DATA_W));
		while (&v)
			v = mc_mem_pkg::elem_t'(rand_bits(`MC_DATA_W));
		return v;
	endfunction

	task automatic fill_random();
		for (int k = 0; k < `MC_MEM_DEPTH; k++)
			stim[k] = rand_elem();
	endtask

	task automatic fill_const(mc_mem_pkg::elem_t v);
		for (int k = 0; k < `MC_MEM_DEPTH; k++)
			stim[k] = v;
	endtask

	// drives one burst and waits for all expected beats
	task automatic issue(string name, mc_op_pkg::action_t act, int n_in, int n_out);
		cur_test  = name;
		got_beats = 0;
		exp_beats = n_out;
		budget    = budget + 4 * cur_side * cur_side + 20;
		for (int k = 0; k < n_in; k++) begin
			@(negedge clk);
			in_valid = 1'b1;
			action   = act;
			size     = cur_code;
			in_data  = stim[k];
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_data  = '0;
		while (got_beats < exp_beats)
			@(posedge clk);
		// a few quiet cycles catch extra beats
		repeat (3) @(posedge clk);
		check_count(name, exp_beats, got_beats);
	endtask

	task automatic run_setup(string name, mc_op_pkg::size_code_t code);
		int n;
		cur_code = code;
		cur_side = 2 << code;
		n        = cur_side * cur_side;
		for (int k = 0; k < n; k++) begin
			model[k] = stim[k];
			exp_q.push_back(stim[k]);
		end
		issue(name, mc_op_pkg::SETUP, n, n);
	endtask

	task automatic run_add(string name);
		int n;
		n = cur_side * cur_side;
		for (int k = 0; k < n; k++) begin
			model[k] = mod_add(model[k], stim[k]);
			exp_q.push_back(model[k]);
		end
		issue(name, mc_op_pkg::ADDITION, n, n);
	endtask

	task automatic run_rearr(string name, mc_op_pkg::action_t act);
		mc_mem_pkg::elem_t tmp [0:`MC_MEM_DEPTH-1];
		int n;
		n = cur_side * cur_side;
		for (int k = 0; k < n; k++)
			tmp[rearr_dst(act, cur_side, k)] = model[k];
		for (int k = 0; k < n; k++)
			model[k] = tmp[k];
		exp_q.push_back('0);
		issue(name, act, 1, 1);
	endtask

	// compare process samples outputs on the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				got_beats = got_beats + 1;
				if (exp_q.size() > 0)
					check_elem(cur_test, exp_q.pop_front(), out_data);
			end else begin
				check_elem($sformatf("%s idle", cur_test), '0, out_data);
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > budget) begin
			$display("watchdog: no response from the DUT within %0d cycles", budget);
			abort_run();
		end
	end

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		size      = '0;
		action    = mc_op_pkg::SETUP;
		lfsr      = 32'h49075605;
		elem_max  = '1;
		near_max  = {{(`MC_DATA_W-1){1'b1}}, 1'b0};
		cur_code  = '0;
		cur_side  = 2;
		got_beats = 0;
		exp_beats = 0;
		cycles    = 0;
		budget    = 20;
		cur_test  = "reset";

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_count("reset out_valid", 0, int'(out_valid));
		check_elem("reset out_data", '0, out_data);

		for (int code = 0; code < 4; code++) begin
			fill_random();
			run_setup($sformatf("setup side %0d", 2 << code), mc_op_pkg::size_code_t'(code));
		end

		// sums that wrap and sums of exactly 2^31-1
		fill_random();
		run_setup("addition base", 2'd2);
		for (int k = 0; k < `MC_MEM_DEPTH; k++) begin
			case (k % 3)
				0:       stim[k] = (model[k] == '0) ? '0 : elem_max - model[k];
				1:       stim[k] = near_max;
				default: stim[k] = rand_elem();
			endcase
		end
		run_add("addition wrap");
		fill_random();
		run_add("addition stored");

		for (int code = 0; code < 4; code++) begin
			fill_random();
			run_setup($sformatf("rearrange base side %0d", 2 << code),
				mc_op_pkg::size_code_t'(code));
			fill_const('0);
			run_rearr("transpose", mc_op_pkg::TRANSPOSE);
			run_add("transpose readback");
			run_rearr("mirror", mc_op_pkg::MIRROR);
			run_add("mirror readback");
			run_rearr("rotate", mc_op_pkg::ROTATE);
			run_add("rotate readback");
		end

		// four quarter turns give the original back
		fill_random();
		run_setup("rotate4 base", 2'd3);
		for (int k = 0; k < `MC_MEM_DEPTH; k++)
			saved[k] = model[k];
		for (int i = 0; i < 4; i++)
			run_rearr($sformatf("rotate4 turn %0d", i), mc_op_pkg::ROTATE);
		for (int k = 0; k < `MC_MEM_DEPTH; k++)
			model[k] = saved[k];
		fill_const('0);
		run_add("rotate4 readback");

		for (int i = 0; i < 16; i++) begin
			sel = int'(rand_bits(3) % 5);
			case (sel)
				0: begin
					fill_random();
					run_setup("random setup", mc_op_pkg::size_code_t'(rand_bits(2)));
				end
				1: begin
					fill_random();
					run_add("random addition");
				end
				2:       run_rearr("random transpose", mc_op_pkg::TRANSPOSE);
				3:       run_rearr("random mirror", mc_op_pkg::MIRROR);
				default: run_rearr("random rotate", mc_op_pkg::ROTATE);
			endcase
		end

		$display("test passed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+src
+incdir+sim
src/mc_op_pkg.sv
src/mc_mem_pkg.sv
src/matrix_ram.sv
src/perm_addr.sv
src/mc_ctrl.sv
src/mc_top.sv
sim/tb_mc.sv

// File: Makefile
FLIST = flist.f
RTL   = src/mc_op_pkg.sv src/mc_mem_pkg.sv src/matrix_ram.sv src/perm_addr.sv \
        src/mc_ctrl.sv src/mc_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+src $(RTL) --top-module mc_top
	verilator --lint-only --timing -f $(FLIST) --top-module tb_mc

sim:
	verilator --binary --timing -j 0 -f $(FLIST) --top-module tb_mc -Mdir obj_dir
	./obj_dir/Vtb_mc

clean:
	rm -rf obj_dir
